// File: source/mandel_fixed_pkg.sv
// Fixed-point number format shared by the Mandelbrot engine and its interface.
// Coordinates are signed with 3 integer bits and FRAC_BITS fraction bits.
package mandel_fixed_pkg;

    // Coordinate word
    localparam int BITWIDTH  = 11;
    localparam int FRAC_BITS = 8;

    // Iteration counter
    localparam int CTRWIDTH = 7;

    // Reported pixel value
    localparam int PIX_WIDTH = 4;

    // Products and squared magnitude need the full product plus a carry
    localparam int WIDE_WIDTH = 2 * BITWIDTH + 1;

    typedef logic signed [BITWIDTH-1:0]   coord_t;
    typedef logic        [CTRWIDTH-1:0]   ctr_t;
    typedef logic signed [WIDE_WIDTH-1:0] wide_t;

    // 4.0 after the product has been scaled back by FRAC_BITS
    localparam wide_t ESCAPE_LIMIT = 4 << FRAC_BITS;

endpackage

// File: source/mandel_cfg_pkg.sv
// Layout of the 33-bit configuration word loaded over the serial pins.
// The receiver slices the shift register by these positions into cfg_t.
package mandel_cfg_pkg;

    localparam int CFG_WIDTH = 33;

    // Real offset
    localparam int CR_LSB = 0;
    localparam int CR_MSB = 10;

    // Imaginary offset
    localparam int CI_LSB = 11;
    localparam int CI_MSB = 21;

    // Step scaling as a left shift of the pixel position
    localparam int SCALE_LSB = 22;
    localparam int SCALE_MSB = 23;

    // Which four counter bits are reported
    localparam int SEL_LSB = 24;
    localparam int SEL_MSB = 25;

    // Iteration limit
    localparam int MAXC_LSB = 26;
    localparam int MAXC_MSB = 32;

    // Fields from bit 32 down to bit 0
    typedef struct packed {
        mandel_fixed_pkg::ctr_t   max_ctr;
        logic [1:0]               ctr_select;
        logic [1:0]               scaling;
        mandel_fixed_pkg::coord_t ci_offset;
        mandel_fixed_pkg::coord_t cr_offset;
    } cfg_t;

endpackage

// File: source/engine_if.sv
// Pixel handshake between the render sequencer and the Mandelbrot engine.
// The sequencer issues run pulses, the engine reports running, last and count.
`timescale 1ns/1ns

interface engine_if;
    import mandel_fixed_pkg::*;

    logic                 run;       // Start one pixel
    logic                 new_frame; // With the first run of a frame
    logic                 running;
    logic                 last;      // Current pixel is the final one
    logic [PIX_WIDTH-1:0] count;

    modport sequencer (
        output run,
        output new_frame,
        input  running,
        input  last,
        input  count
    );

    modport engine (
        input  run,
        input  new_frame,
        output running,
        output last,
        output count
    );

endinterface

// File: source/serial_config_rx.sv
// Serial configuration receiver. Shifts the word in LSB first while the enable
// is high and pulses start when the enable drops.
`timescale 1ns/1ns

module serial_config_rx (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cfg_sen,
    input  logic                 cfg_sclk,
    input  logic                 cfg_sdata,
    output mandel_cfg_pkg::cfg_t cfg,
    output logic                 start
);
    import mandel_cfg_pkg::*;

    logic [2:0]           sen_sync;
    logic [2:0]           sclk_sync;
    logic [2:0]           sdata_sync;
    logic [CFG_WIDTH-1:0] shreg;
    logic                 sclk_rise;

    // Pins into the clock domain
    always_ff @(posedge clk) begin
        if (reset) begin
            sen_sync   <= '0;
            sclk_sync  <= '0;
            sdata_sync <= '0;
            start      <= 1'b0;
        end else begin
            sen_sync   <= {sen_sync[1:0], cfg_sen};
            sclk_sync  <= {sclk_sync[1:0], cfg_sclk};
            sdata_sync <= {sdata_sync[1:0], cfg_sdata};
            start      <= sen_sync[2] & ~sen_sync[1]; // Enable falling edge
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];

    // One bit per serial clock rise while enabled
    always_ff @(posedge clk) begin
        if (sen_sync[2] && sclk_rise) begin
            shreg <= {sdata_sync[2], shreg[CFG_WIDTH-1:1]};
        end
    end

    // Fields by position
    always_comb begin
        cfg.cr_offset  = shreg[CR_MSB:CR_LSB];
        cfg.ci_offset  = shreg[CI_MSB:CI_LSB];
        cfg.scaling    = shreg[SCALE_MSB:SCALE_LSB];
        cfg.ctr_select = shreg[SEL_MSB:SEL_LSB];
        cfg.max_ctr    = shreg[MAXC_MSB:MAXC_LSB];
    end

endmodule

// File: source/mandel_engine.sv
// Mandelbrot pixel engine. Steps through the frame in raster order and
// iterates z = z^2 + c for one pixel per run pulse.
`timescale 1ns/1ns

module mandel_engine #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 6
) (
    input  logic                 clk,
    input  logic                 reset,
    input  mandel_cfg_pkg::cfg_t cfg,
    engine_if.engine             eng
);
    import mandel_fixed_pkg::*;

    localparam int XW = (IMG_W > 1) ? $clog2(IMG_W) : 1;
    localparam int YW = (IMG_H > 1) ? $clog2(IMG_H) : 1;

    // Raster position
    logic [XW-1:0] x;
    logic [YW-1:0] y;
    logic [XW-1:0] x_eff;
    logic [YW-1:0] y_eff;

    // Point and orbit
    coord_t cr;
    coord_t ci;
    coord_t zr;
    coord_t zi;
    coord_t cr_load;
    coord_t ci_load;
    ctr_t   ctr;

    // Full-width arithmetic
    wide_t zr_sq;
    wide_t zi_sq;
    wide_t zr_zi;
    wide_t mag;
    wide_t zr_next;
    wide_t zi_next;

    logic escape;
    logic stop;

    // A new frame starts from the origin in the same cycle as its first run
    assign x_eff = eng.new_frame ? '0 : x;
    assign y_eff = eng.new_frame ? '0 : y;

    assign cr_load = cfg.cr_offset + (coord_t'(x_eff) << cfg.scaling);
    assign ci_load = cfg.ci_offset + (coord_t'(y_eff) << cfg.scaling);

    always_comb begin
        zr_sq   = zr * zr;
        zi_sq   = zi * zi;
        zr_zi   = zr * zi;
        mag     = (zr_sq + zi_sq) >>> FRAC_BITS;
        zr_next = ((zr_sq - zi_sq) >>> FRAC_BITS) + cr;
        zi_next = ((zr_zi <<< 1) >>> FRAC_BITS) + ci; // 2*zr*zi + ci
    end

    assign escape = (mag >= ESCAPE_LIMIT);
    assign stop   = escape || (ctr == cfg.max_ctr);

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            eng.running <= 1'b0;
            x           <= '0;
            y           <= '0;
        end else if (eng.run) begin
            eng.running <= 1'b1;
            x           <= x_eff;
            y           <= y_eff;
        end else if (eng.running && stop) begin
            eng.running <= 1'b0;
            // Advance to the next raster position
            if (x == XW'(IMG_W - 1)) begin
                x <= '0;
                if (y == YW'(IMG_H - 1)) begin
                    y <= '0;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // Point, orbit and counter
    always_ff @(posedge clk) begin
        if (eng.run) begin
            cr       <= cr_load;
            ci       <= ci_load;
            zr       <= '0;
            zi       <= '0;
            ctr      <= '0;
            eng.last <= (x_eff == XW'(IMG_W - 1)) && (y_eff == YW'(IMG_H - 1));
        end else if (eng.running && !stop) begin
            zr  <= zr_next[BITWIDTH-1:0]; // Truncated to a coordinate
            zi  <= zi_next[BITWIDTH-1:0];
            ctr <= ctr + 1'b1;
        end
    end

    // Four counter bits from ctr_select upward
    assign eng.count = ctr[cfg.ctr_select +: PIX_WIDTH];

endmodule

// File: source/render_sequencer.sv
// Frame sequencer. Launches one engine run per pixel after a start pulse and
// strobes each finished pixel value out, flagging the frame's last one.
`timescale 1ns/1ns

module render_sequencer (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    engine_if.sequencer                          eng,
    output logic                                 pixel_valid,
    output logic [mandel_fixed_pkg::PIX_WIDTH-1:0] pixel_count,
    output logic                                 frame_done,
    output logic                                 busy
);
    typedef enum logic [1:0] {
        IDLE,
        LAUNCH,
        WAIT_PIXEL,
        NEXT
    } state_t;

    state_t state;
    logic   running_q;
    logic   pixel_end;

    // Engine just finished a pixel
    assign pixel_end = running_q & ~eng.running;

    always_ff @(posedge clk) begin
        pixel_count <= eng.count; // Value of the pixel that just finished
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= IDLE;
            running_q     <= 1'b0;
            eng.run       <= 1'b0;
            eng.new_frame <= 1'b0;
            pixel_valid   <= 1'b0;
            frame_done    <= 1'b0;
        end else begin
            running_q     <= eng.running;
            eng.run       <= 1'b0;
            eng.new_frame <= 1'b0;
            pixel_valid   <= 1'b0;
            frame_done    <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= LAUNCH;
                    end
                end
                LAUNCH: begin
                    eng.run       <= 1'b1;
                    eng.new_frame <= 1'b1; // Engine restarts at pixel 0
                    state         <= WAIT_PIXEL;
                end
                WAIT_PIXEL: begin
                    if (pixel_end) begin
                        pixel_valid <= 1'b1;
                        frame_done  <= eng.last;
                        state       <= eng.last ? IDLE : NEXT;
                    end
                end
                NEXT: begin
                    eng.run <= 1'b1;
                    state   <= WAIT_PIXEL;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign busy = (state != IDLE);

endmodule

// File: source/mandel_render_top.sv
// Mandelbrot renderer top level. Configure over the serial pins, then drop the
// enable to render one frame as a stream of 4-bit pixel strobes.
`timescale 1ns/1ns

module mandel_render_top #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 6
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 cfg_sen,
    input  logic                                 cfg_sclk,
    input  logic                                 cfg_sdata,
    output logic                                 pixel_valid,
    output logic [mandel_fixed_pkg::PIX_WIDTH-1:0] pixel_count,
    output logic                                 frame_done,
    output logic                                 busy
);
    import mandel_cfg_pkg::*;

    cfg_t cfg;
    logic start;

    engine_if eng_bus ();

    serial_config_rx u_rx (
        .clk       (clk),
        .reset     (reset),
        .cfg_sen   (cfg_sen),
        .cfg_sclk  (cfg_sclk),
        .cfg_sdata (cfg_sdata),
        .cfg       (cfg),
        .start     (start)
    );

    render_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .eng         (eng_bus.sequencer),
        .pixel_valid (pixel_valid),
        .pixel_count (pixel_count),
        .frame_done  (frame_done),
        .busy        (busy)
    );

    mandel_engine #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_engine (
        .clk   (clk),
        .reset (reset),
        .cfg   (cfg),
        .eng   (eng_bus.engine)
    );

endmodule

// File: include/mandel_tb_model.svh
// Testbench helpers for the Mandelbrot renderer, included inside the testbench module.
// Serial loader for the configuration word and the reference pixel model.
`ifndef MANDEL_TB_MODEL_SVH
`define MANDEL_TB_MODEL_SVH

// Word goes out bit 0 first and data only changes while the serial clock is low
task automatic send_config(input cfg_t word);
    logic [CFG_WIDTH-1:0] bits;
    int                   i;
    bits = word;
    @(posedge clk);
    cfg_sen   <= 1'b1;
    cfg_sdata <= bits[0];
    repeat (4) @(posedge clk); // Enable through the synchronizer first
    for (i = 0; i < CFG_WIDTH; i++) begin
        cfg_sclk <= 1'b1;
        repeat (4) @(posedge clk);
        cfg_sclk <= 1'b0;
        if (i < CFG_WIDTH - 1) begin
            cfg_sdata <= bits[i + 1];
        end
        repeat (4) @(posedge clk);
    end
    cfg_sen <= 1'b0; // Falling enable starts the frame
endtask

// Two's complement wrap to a coordinate
function automatic int wrap_coord(input int value);
    int t;
    t = value & ((1 << BITWIDTH) - 1);
    if (t >= (1 << (BITWIDTH - 1))) begin
        t = t - (1 << BITWIDTH);
    end
    return t;
endfunction

// Iterations done before escape or the limit
function automatic int escape_count(input cfg_t c, input int px, input int py);
    int cr;
    int ci;
    int zr;
    int zi;
    int zr_sq;
    int zi_sq;
    int zr_new;
    int iter;
    cr   = wrap_coord(int'(c.cr_offset) + (px << c.scaling));
    ci   = wrap_coord(int'(c.ci_offset) + (py << c.scaling));
    zr   = 0;
    zi   = 0;
    iter = 0;
    forever begin
        zr_sq = zr * zr;
        zi_sq = zi * zi;
        if (((zr_sq + zi_sq) >>> FRAC_BITS) >= (4 << FRAC_BITS)) break; // |z|^2 >= 4.0
        if (iter == int'(c.max_ctr)) break;
        zr_new = wrap_coord(((zr_sq - zi_sq) >>> FRAC_BITS) + cr);
        zi     = wrap_coord(((2 * zr * zi) >>> FRAC_BITS) + ci);
        zr     = zr_new;
        iter++;
    end
    return iter;
endfunction

function automatic logic [PIX_WIDTH-1:0] expected_pixel(input cfg_t c, input int px,
                                                        input int py);
    int iter;
    iter = escape_count(c, px, py);
    return PIX_WIDTH'((iter >> c.ctr_select) & 15); // Slice picked by ctr_select
endfunction

`endif

// File: verif/mandel_render_tb.sv
// Testbench for the Mandelbrot renderer. Loads each table entry over the serial
// pins, renders one frame and checks every pixel against the reference model.
`timescale 1ns/1ns

module mandel_render_tb;
    import mandel_fixed_pkg::*;
    import mandel_cfg_pkg::*;

    localparam int IMG_W        = 4;
    localparam int IMG_H        = 3;
    localparam int NUM_PIXELS   = IMG_W * IMG_H;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 8;
    // Serial load plus every pixel at the full limit plus margin
    localparam int TEST_CYCLES  = CFG_WIDTH * 8 + NUM_PIXELS * (128 + 4) + 50;

    logic                 clk;
    logic                 reset;
    logic                 cfg_sen;
    logic                 cfg_sclk;
    logic                 cfg_sdata;
    logic                 pixel_valid;
    logic [PIX_WIDTH-1:0] pixel_count;
    logic                 frame_done;
    logic                 busy;

    // Test table
    string test_name [NUM_TESTS];
    cfg_t  test_cfg  [NUM_TESTS];
    int    test_done [NUM_TESTS];

    logic [PIX_WIDTH-1:0] got_pix[$];
    int                   done_seen;
    int                   errors;
    int                   seed;
    logic                 quiet;   // Outputs must stay low
    logic                 valid_q;

    `include "mandel_tb_model.svh"

    mandel_render_top #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) dut (
        .clk         (clk),
        .reset       (reset),
        .cfg_sen     (cfg_sen),
        .cfg_sclk    (cfg_sclk),
        .cfg_sdata   (cfg_sdata),
        .pixel_valid (pixel_valid),
        .pixel_count (pixel_count),
        .frame_done  (frame_done),
        .busy        (busy)
    );

    task automatic add_test(input int idx, input string name, input int max_ctr,
                            input int sel, input int scale, input int cr, input int ci);
        test_name[idx]            = name;
        test_cfg[idx].max_ctr     = ctr_t'(max_ctr);
        test_cfg[idx].ctr_select  = 2'(sel);
        test_cfg[idx].scaling     = 2'(scale);
        test_cfg[idx].cr_offset   = coord_t'(cr);
        test_cfg[idx].ci_offset   = coord_t'(ci);
        test_done[idx]            = 1;
    endtask

    task automatic build_test_table();
        int rnd_cr;
        int rnd_ci;
        rnd_cr = $random(seed);
        rnd_ci = $random(seed);
        add_test(0, "outside_s0", 20, 0, 0, -512, -256);
        add_test(1, "inside_s1", 20, 0, 1, -128, 0);
        add_test(2, "outside_s2", 20, 1, 2, 512, 256);
        add_test(3, "edge_s3", 127, 2, 3, -192, 26);
        add_test(4, "limit_one", 1, 0, 0, -64, 0);
        add_test(5, "inside_sel3", 127, 3, 0, -256, 0);
        add_test(6, "random_offsets", 20, 1, 1, rnd_cr, rnd_ci);
        add_test(7, "boundary_s2", 127, 0, 2, 80, 128);
    endtask

    // Enable pulse and stray serial clocks while a frame renders
    task automatic disturb_serial_pins();
        repeat (2) @(posedge clk);
        cfg_sen <= 1'b1;
        repeat (3) @(posedge clk);
        cfg_sen <= 1'b0; // Second start
        repeat (4) @(posedge clk);
        repeat (4) begin
            cfg_sclk  <= 1'b1;
            cfg_sdata <= ~cfg_sdata;
            repeat (2) @(posedge clk);
            cfg_sclk <= 1'b0;
            repeat (2) @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_TESTS * TEST_CYCLES + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run hung waiting for pixels");
        $display("Simulation failed");
        $finish;
    end

    // Output monitor
    always @(posedge clk) begin
        if (reset) begin
            valid_q = 1'b0;
        end else begin
            if (quiet && (pixel_valid || frame_done || busy)) begin
                errors++;
                $display("Outputs went active while the configuration was loading");
            end
            if (pixel_valid) begin
                if (valid_q) begin
                    errors++;
                    $display("pixel_valid stayed high for more than one cycle");
                end
                if (!frame_done && busy !== 1'b1) begin
                    errors++;
                    $display("busy was low while the frame was still rendering");
                end
                got_pix.push_back(pixel_count);
                if (frame_done) begin
                    done_seen++;
                end
                if (frame_done != (got_pix.size() == NUM_PIXELS)) begin
                    errors++;
                    $display("frame_done came with pixel %0d of the frame", got_pix.size());
                end
            end else if (frame_done) begin
                errors++;
                $display("frame_done rose without pixel_valid");
            end
            valid_q = pixel_valid;
        end
    end

    initial begin
        int                   t;
        int                   p;
        logic [PIX_WIDTH-1:0] exp_pix;
        reset     = 1'b1;
        cfg_sen   = 1'b0;
        cfg_sclk  = 1'b0;
        cfg_sdata = 1'b0;
        errors    = 0;
        done_seen = 0;
        quiet     = 1'b1;
        seed      = 24;
        build_test_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (t = 0; t < NUM_TESTS; t++) begin
            got_pix.delete();
            done_seen = 0;
            quiet     = 1'b1;
            send_config(test_cfg[t]);
            quiet = 1'b0;
            disturb_serial_pins();
            wait (done_seen >= test_done[t]);
            @(posedge clk);
            if (busy !== 1'b0) begin
                errors++;
                $display("ERR %s busy after frame_done expected 0 actual %b", test_name[t],
                         busy);
            end
            repeat (8) @(posedge clk); // Nothing more may follow
            if (done_seen != test_done[t]) begin
                errors++;
                $display("ERR %s frame_done expected %0d actual %0d", test_name[t],
                         test_done[t], done_seen);
            end
            if (got_pix.size() != NUM_PIXELS) begin
                errors++;
                $display("ERR %s strobes expected %0d actual %0d", test_name[t],
                         NUM_PIXELS, got_pix.size());
            end
            for (p = 0; p < got_pix.size() && p < NUM_PIXELS; p++) begin
                exp_pix = expected_pixel(test_cfg[t], p % IMG_W, p / IMG_W);
                if (got_pix[p] !== exp_pix) begin
                    errors++;
                    $display("ERR %s pixel %0d expected %0d actual %0d", test_name[t], p,
                             exp_pix, got_pix[p]);
                end
                if (test_cfg[t].max_ctr == 1 && test_cfg[t].ctr_select == 0 &&
                    got_pix[p] > 1) begin
                    errors++;
                    $display("ERR %s pixel %0d expected at most 1 actual %0d", test_name[t],
                             p, got_pix[p]);
                end
            end
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: mandel_render_top.f
+incdir+include
source/mandel_fixed_pkg.sv
source/mandel_cfg_pkg.sv
source/engine_if.sv
source/serial_config_rx.sv
source/mandel_engine.sv
source/render_sequencer.sv
source/mandel_render_top.sv
verif/mandel_render_tb.sv
